/* dv/cpr_loader_tb.sv */
module cpr_loader_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import cart_pkg::*;

    localparam int    text_bits = 8 * 128;
    localparam string stim_path = "dv/cpr_stim.txt";

    typedef logic [text_bits-1:0]      text_t;    // Right-aligned ASCII as $fgets leaves it
    typedef logic [rom_addr_width+7:0] write_t;   // {addr, data}

    logic        clk_sys;
    logic        reset;
    logic        ioctl_download;
    logic        ioctl_wr;
    logic [7:0]  ioctl_index;
    logic [7:0]  ioctl_dout;
    rom_addr_t   rom_addr;
    logic [7:0]  rom_data;
    logic        rom_wr;
    logic        auto_boot;
    logic [15:0] boot_addr;
    logic        plus_bios_valid;
    logic [7:0]  plus_bios_version;
    logic [15:0] plus_bios_checksum;

    write_t got_q[$];           // Filled by the ROM-write monitor
    write_t exp_q[$];           // From W records
    text_t  test_name;
    int     test_errors  = 0;
    int     total_errors = 0;
    int     tests_run    = 0;
    int     tests_bad    = 0;
    int     cycle_count  = 0;
    int     cycle_limit  = 0;

    cpr_loader #(
        .bank_bytes (16)
    ) cpr_loader_i (
        .clk_sys            (clk_sys),
        .reset              (reset),
        .ioctl_download     (ioctl_download),
        .ioctl_wr           (ioctl_wr),
        .ioctl_index        (ioctl_index),
        .ioctl_dout         (ioctl_dout),
        .rom_addr           (rom_addr),
        .rom_data           (rom_data),
        .rom_wr             (rom_wr),
        .auto_boot          (auto_boot),
        .boot_addr          (boot_addr),
        .plus_bios_valid    (plus_bios_valid),
        .plus_bios_version  (plus_bios_version),
        .plus_bios_checksum (plus_bios_checksum)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    // rom_wr is a one-cycle pulse, so exactly one falling edge sees it
    always @(negedge clk_sys) begin
        if (!reset && rom_wr) begin
            got_q.push_back({rom_addr, rom_data});
        end
    end

    always @(posedge clk_sys) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            $display("test failed");
            $finish;
        end
    end

    function automatic int text_len(input text_t s);
        int n;
        n = 0;
        while (n < text_bits / 8 && s[n*8 +: 8] != 8'h00) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic [3:0] hex_digit(input logic [7:0] c);
        if (c >= 8'h30 && c <= 8'h39) begin
            return 4'(c - 8'h30);
        end else if (c >= 8'h61 && c <= 8'h66) begin
            return 4'(c - 8'h57);     // a to f
        end else if (c >= 8'h41 && c <= 8'h46) begin
            return 4'(c - 8'h37);     // A to F
        end
        return 4'h0;
    endfunction

    // Byte k in file order with the first character highest
    function automatic logic [7:0] hex_byte(input text_t s, input int len, input int k);
        int p;
        p = len - 1 - 2 * k;
        return {hex_digit(s[p*8 +: 8]), hex_digit(s[(p-1)*8 +: 8])};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %0s %0s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic send_byte(input logic [7:0] data, input logic [7:0] index);
        @(negedge clk_sys);
        ioctl_wr    = 1'b1;
        ioctl_dout  = data;
        ioctl_index = index;
        @(negedge clk_sys);
        ioctl_wr = 1'b0;              // Idle cycle between strobes
    endtask

    task automatic start_test(input text_t name);
        test_name   = name;
        test_errors = 0;
        got_q.delete();
        exp_q.delete();
        @(negedge clk_sys);
        ioctl_download = 1'b1;
    endtask

    task automatic finish_test(input logic [31:0] e_auto, input logic [31:0] e_boot,
                               input logic [31:0] e_valid, input logic [31:0] e_ver,
                               input logic [31:0] e_csum);
        write_t got;
        write_t want;
        @(negedge clk_sys);
        ioctl_download = 1'b0;
        @(negedge clk_sys);           // Last write and format fields have landed
        while (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            if (got_q.size() == 0) begin
                $display("%0s: expected ROM write 0x%0h <= 0x%0h never happened",
                         test_name, want[rom_addr_width+7:8], want[7:0]);
                test_errors++;
            end else begin
                got = got_q.pop_front();
                check_value("rom_addr", 32'(want[rom_addr_width+7:8]),
                            32'(got[rom_addr_width+7:8]));
                check_value("rom_data", 32'(want[7:0]), 32'(got[7:0]));
            end
        end
        while (got_q.size() > 0) begin
            got = got_q.pop_front();
            $display("%0s: unexpected ROM write 0x%0h <= 0x%0h",
                     test_name, got[rom_addr_width+7:8], got[7:0]);
            test_errors++;
        end
        check_value("auto_boot", e_auto, 32'(auto_boot));
        check_value("boot_addr", e_boot, 32'(boot_addr));
        check_value("plus_bios_valid", e_valid, 32'(plus_bios_valid));
        check_value("plus_bios_version", e_ver, 32'(plus_bios_version));
        check_value("plus_bios_checksum", e_csum, 32'(plus_bios_checksum));
        tests_run++;
        if (test_errors == 0) begin
            $display("ok    %0s", test_name);
        end else begin
            $display("FAIL  %0s (%0d errors)", test_name, test_errors);
            tests_bad++;
            total_errors += test_errors;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          len;
        int          total_bytes;
        logic        in_test;
        text_t       line;
        text_t       field;
        logic [7:0]  kind;
        logic [7:0]  index;
        logic [31:0] addr;
        logic [31:0] e_auto;
        logic [31:0] e_boot;
        logic [31:0] e_valid;
        logic [31:0] e_ver;
        logic [31:0] e_csum;

        reset          = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_index    = 8'h00;
        ioctl_dout     = 8'h00;
        total_bytes    = 0;
        in_test        = 1'b0;

        // First pass only counts download bytes to size the timeout
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %0s", stim_path);
            total_errors = 1;
        end else begin
            while (!$feof(fd)) begin
                line  = '0;
                field = '0;
                kind  = 8'h00;
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s %s", kind, field);
                    if (n >= 2 && kind == "B") begin
                        total_bytes += text_len(field) / 2;
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = total_bytes * 4 + 200;

        repeat (4) @(negedge clk_sys);
        reset = 1'b0;

        if (total_errors == 0) begin
            fd = $fopen(stim_path, "r");
            while (!$feof(fd)) begin
                line  = '0;
                field = '0;
                kind  = 8'h00;
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s", kind);
                end
                case (kind)
                    "T": begin
                        if (in_test) begin
                            $display("%0s ended without an E record", test_name);
                            total_errors++;
                        end
                        n = $sscanf(line, "%s %s", kind, field);
                        start_test(field);
                        in_test = 1'b1;
                    end
                    "B": begin
                        n = $sscanf(line, "%s %s %h", kind, field, index);
                        if (n < 3) begin
                            index = cpr_index;
                        end
                        len = text_len(field);
                        for (int k = 0; k < len / 2; k++) begin
                            send_byte(hex_byte(field, len, k), index);
                        end
                    end
                    "W": begin
                        n = $sscanf(line, "%s %h %s", kind, addr, field);
                        len = text_len(field);
                        for (int k = 0; k < len / 2; k++) begin
                            exp_q.push_back({rom_addr_t'(addr + k), hex_byte(field, len, k)});
                        end
                    end
                    "E": begin
                        n = $sscanf(line, "%s %h %h %h %h %h", kind, e_auto, e_boot,
                                    e_valid, e_ver, e_csum);
                        finish_test(e_auto, e_boot, e_valid, e_ver, e_csum);
                        in_test = 1'b0;
                    end
                    default: ;                // Comment or blank line
                endcase
            end
            $fclose(fd);
            if (in_test) begin
                $display("%0s ended without an E record", test_name);
                total_errors++;
            end
        end

        $display("Summary: %0d run, %0d ok, %0d with errors",
                 tests_run, tests_run - tests_bad, tests_bad);
        if (total_errors == 0 && tests_run > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* dv/cpr_stim.txt */
# T name | B hex-bytes [index] | W first-addr hex-data | E auto_boot boot_addr valid version checksum
# All values hex, bytes in download order, index defaults to 05
T cb02_block
B 524946461b000000414d5321
B 6362303203000000a1b2c3
W 0020 a1b2c3
E 0 0000 1 00 0000
T fmt_boot
B 5249464620000000414d5321
B 666d7420080000000021003412004000
E 1 4000 1 21 1234
T fmt_no_boot
B 5249464620000000414d5321
B 666d7420080000000021003412000000
E 0 0000 1 21 1234
T bad_signature
B 524946581b000000414d5321
B 6362303003000000a1b2c3
E 0 0000 0 00 0000
T skip_chunks
B 5249464640000000414d5321
B 6a756e6b020000001122
B 636234300100000033
B 6362303300000000
B 63623031020000004455
W 0010 4455
E 0 0000 1 00 0000
T oversized_block
B 5249464650000000414d5321
B 6362303014000000808182838485868788898a8b8c8d8e8f90919293
B 63623031010000005a
W 0000 808182838485868788898a8b8c8d8e8f
W 0010 5a
E 0 0000 1 00 0000
T wrong_index
B 524946461b000000414d5321 01
B 6362303203000000a1b2c3 01
E 0 0000 0 00 0000

/* hw/cart_block_writer.sv */
module cart_block_writer #(
    parameter int unsigned bank_bytes = cart_pkg::default_bank_bytes
) (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  payload_valid,
    input  riff_pkg::chunk_kind_t payload_kind,
    input  logic [31:0]           payload_offset,
    input  logic [7:0]            payload_data,
    input  cart_pkg::block_num_t  block_num,
    output cart_pkg::rom_addr_t   rom_addr,
    output logic [7:0]            rom_data,
    output logic                  rom_wr
);

    import cart_pkg::*;
    import riff_pkg::*;

    // Bank size is a power of two, so the base is a shift
    localparam int bank_shift = $clog2(bank_bytes);

    rom_addr_t block_base;
    rom_addr_t byte_addr;
    logic      in_bank;
    logic      write_hit;

    assign block_base = rom_addr_t'(block_num) << bank_shift;
    assign byte_addr  = block_base + rom_addr_t'(payload_offset);
    assign in_bank    = payload_offset < bank_bytes;   // Tail of oversized block is dropped
    assign write_hit  = payload_valid && (payload_kind == kind_block) && in_bank;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rom_wr <= 1'b0;
        end else begin
            rom_wr <= write_hit;    // One-cycle strobe
        end
    end

    always_ff @(posedge clk_sys) begin
        if (write_hit) begin
            rom_addr <= byte_addr;
            rom_data <= payload_data;
        end
    end

endmodule

/* hw/cart_pkg.sv */
package cart_pkg;

    // ROM side of the cartridge loader

    localparam int rom_addr_width = 23;               // 8 MB of cartridge space

    typedef logic [rom_addr_width-1:0] rom_addr_t;

    // A CPR image holds at most 32 banks, cb00 to cb31
    localparam int max_blocks = 32;

    typedef logic [$clog2(max_blocks)-1:0] block_num_t;

    // Plus/GX4000 cartridge banks are 16 KB
    localparam int unsigned default_bank_bytes = 16384;

    localparam logic [7:0] cpr_index = 8'd5;          // Download slot used for .cpr files

endpackage

/* hw/cpr_format_decoder.sv */
module cpr_format_decoder (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  download_start,
    input  logic                  form_ok,
    input  logic                  payload_valid,
    input  riff_pkg::chunk_kind_t payload_kind,
    input  logic [31:0]           payload_offset,
    input  logic [7:0]            payload_data,
    output logic                  auto_boot,
    output logic [15:0]           boot_addr,
    output logic                  plus_bios_valid,
    output logic [7:0]            plus_bios_version,
    output logic [15:0]           plus_bios_checksum
);

    import riff_pkg::*;

    logic       fmt_byte;
    logic [7:0] low_q;        // Low half of the field being assembled

    assign fmt_byte = payload_valid && (payload_kind == kind_fmt);

    always_ff @(posedge clk_sys) begin
        if (reset || download_start) begin
            auto_boot          <= 1'b0;
            boot_addr          <= 16'h0000;
            plus_bios_valid    <= 1'b0;
            plus_bios_version  <= 8'h00;
            plus_bios_checksum <= 16'h0000;
        end else begin
            plus_bios_valid <= form_ok;
            if (fmt_byte) begin
                case (payload_offset)
                    32'd1: plus_bios_version <= payload_data;
                    32'd4: plus_bios_checksum <= {payload_data, low_q};
                    32'd6: begin
                        // Zero exec address means no auto-boot
                        if ({payload_data, low_q} != 16'h0000) begin
                            auto_boot <= 1'b1;
                            boot_addr <= {payload_data, low_q};
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (fmt_byte && ((payload_offset == 32'd3) || (payload_offset == 32'd5))) begin
            low_q <= payload_data;
        end
    end

endmodule

/* hw/cpr_loader.sv */
module cpr_loader #(
    parameter int unsigned bank_bytes = cart_pkg::default_bank_bytes
) (
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                ioctl_download,
    input  logic                ioctl_wr,
    input  logic [7:0]          ioctl_index,
    input  logic [7:0]          ioctl_dout,
    output cart_pkg::rom_addr_t rom_addr,
    output logic [7:0]          rom_data,
    output logic                rom_wr,
    output logic                auto_boot,
    output logic [15:0]         boot_addr,
    output logic                plus_bios_valid,
    output logic [7:0]          plus_bios_version,
    output logic [15:0]         plus_bios_checksum
);

    import cart_pkg::*;
    import riff_pkg::*;

    logic        download_start;
    logic        form_ok;
    logic        payload_valid;
    chunk_kind_t payload_kind;
    logic [31:0] payload_offset;
    logic [7:0]  payload_data;
    block_num_t  block_num;

    riff_parser #(
        .bank_bytes (bank_bytes)
    ) parser_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_index    (ioctl_index),
        .ioctl_dout     (ioctl_dout),
        .download_start (download_start),
        .form_ok        (form_ok),
        .payload_valid  (payload_valid),
        .payload_kind   (payload_kind),
        .payload_offset (payload_offset),
        .payload_data   (payload_data),
        .block_num      (block_num)
    );

    cart_block_writer #(
        .bank_bytes (bank_bytes)
    ) writer_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .payload_valid  (payload_valid),
        .payload_kind   (payload_kind),
        .payload_offset (payload_offset),
        .payload_data   (payload_data),
        .block_num      (block_num),
        .rom_addr       (rom_addr),
        .rom_data       (rom_data),
        .rom_wr         (rom_wr)
    );

    cpr_format_decoder fmt_i (
        .clk_sys            (clk_sys),
        .reset              (reset),
        .download_start     (download_start),
        .form_ok            (form_ok),
        .payload_valid      (payload_valid),
        .payload_kind       (payload_kind),
        .payload_offset     (payload_offset),
        .payload_data       (payload_data),
        .auto_boot          (auto_boot),
        .boot_addr          (boot_addr),
        .plus_bios_valid    (plus_bios_valid),
        .plus_bios_version  (plus_bios_version),
        .plus_bios_checksum (plus_bios_checksum)
    );

endmodule

/* hw/riff_parser.sv */
module riff_parser #(
    parameter int unsigned bank_bytes = cart_pkg::default_bank_bytes
) (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  logic                  ioctl_download,
    input  logic                  ioctl_wr,
    input  logic [7:0]            ioctl_index,
    input  logic [7:0]            ioctl_dout,
    output logic                  download_start,
    output logic                  form_ok,
    output logic                  payload_valid,
    output riff_pkg::chunk_kind_t payload_kind,
    output logic [31:0]           payload_offset,
    output logic [7:0]            payload_data,
    output cart_pkg::block_num_t  block_num
);

    import cart_pkg::*;
    import riff_pkg::*;

    parser_state_t state;
    logic          download_q;
    logic          byte_accept;
    logic          header_byte;
    logic          word_done;
    riff_word_t    word;
    riff_word_t    remaining;     // Payload bytes left in the chunk
    chunk_kind_t   id_kind;
    logic [7:0]    tens;
    logic [7:0]    units;
    logic [7:0]    id_block;

    assign byte_accept    = ioctl_download && ioctl_wr && (ioctl_index == cpr_index);
    assign header_byte    = byte_accept && (state != s_payload);
    assign download_start = ioctl_download && !download_q;

    assign payload_valid = byte_accept && (state == s_payload);
    assign payload_data  = ioctl_dout;

    riff_word_assembler word_asm_i (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .clear      (!ioctl_download),
        .byte_valid (header_byte),
        .byte_data  (ioctl_dout),
        .word_done  (word_done),
        .word       (word)
    );

    // Chunk ID decode, digits live in bits 31:16
    always_comb begin
        tens     = word[23:16] - 8'h30;
        units    = word[31:24] - 8'h30;
        id_block = tens * 8'd10 + units;
        if (word == fmt_sig) begin
            id_kind = kind_fmt;
        end else if ((word[15:0] == cb_prefix) && (tens <= 8'd9) && (units <= 8'd9)
                     && (id_block < max_blocks)) begin
            id_kind = kind_block;
        end else begin
            id_kind = kind_skip;    // Unknown ID or bank out of range
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state      <= s_wait;
            download_q <= 1'b0;
            form_ok    <= 1'b0;
        end else begin
            download_q <= ioctl_download;
            if (download_start) begin
                form_ok <= 1'b0;
            end
            if (!ioctl_download) begin
                state <= s_wait;     // Download over, wait for the next file
            end else if (word_done) begin
                case (state)
                    s_wait: begin
                        if (word == riff_sig) begin
                            state <= s_size;
                        end
                    end
                    s_size: state <= s_form;
                    s_form: begin
                        if (word == form_sig) begin
                            state   <= s_chunk_id;
                            form_ok <= 1'b1;
                        end else begin
                            state <= s_wait;
                        end
                    end
                    s_chunk_id: state <= s_chunk_size;
                    s_chunk_size: begin
                        // Empty chunk has no payload phase
                        state <= (word == '0) ? s_chunk_id : s_payload;
                    end
                    default: state <= s_wait;
                endcase
            end else if (payload_valid && (remaining == 32'd1)) begin
                state <= s_chunk_id;     // Last payload byte
            end
        end
    end

    // Per-chunk bookkeeping, only meaningful while in s_payload
    always_ff @(posedge clk_sys) begin
        if (word_done && (state == s_chunk_id)) begin
            payload_kind <= id_kind;
            block_num    <= block_num_t'(id_block);
        end
        if (word_done && (state == s_chunk_size)) begin
            remaining      <= word;
            payload_offset <= '0;
        end else if (payload_valid) begin
            remaining      <= remaining - 32'd1;
            payload_offset <= payload_offset + 32'd1;
        end
    end

endmodule

/* hw/riff_pkg.sv */
package riff_pkg;

    typedef logic [31:0] riff_word_t;

    // Four-character codes as the word assembler builds them.
    // The first byte of the file lands in bits 7:0.
    localparam riff_word_t riff_sig = 32'h4646_4952;  // "RIFF"
    localparam riff_word_t form_sig = 32'h2153_4d41;  // "AMS!"
    localparam riff_word_t fmt_sig  = 32'h2074_6d66;  // "fmt "

    // Low half of a "cbNN" ID, the two digits follow in bits 31:16
    localparam logic [15:0] cb_prefix = 16'h6263;

    typedef enum logic [1:0] {
        kind_skip,     // Consumed by length only
        kind_fmt,      // Format chunk
        kind_block     // Cartridge ROM bank
    } chunk_kind_t;

    typedef enum logic [2:0] {
        s_wait,        // Expect "RIFF"
        s_size,        // RIFF size, not checked
        s_form,        // Expect "AMS!"
        s_chunk_id,
        s_chunk_size,
        s_payload
    } parser_state_t;

endpackage

/* hw/riff_word_assembler.sv */
module riff_word_assembler (
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                clear,
    input  logic                byte_valid,
    input  logic [7:0]          byte_data,
    output logic                word_done,
    output riff_pkg::riff_word_t word
);

    logic [1:0]  byte_cnt;
    logic [23:0] shift_q;      // Three most recent bytes, newest on top

    // Fourth byte completes the field in the same cycle
    assign word_done = byte_valid && (byte_cnt == 2'd3);
    assign word      = {byte_data, shift_q};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            byte_cnt <= 2'd0;
        end else if (clear) begin
            byte_cnt <= 2'd0;
        end else if (byte_valid) begin
            byte_cnt <= byte_cnt + 2'd1;   // Wraps back to 0 after a full word
        end
    end

    // Bytes enter at the top so the word ends up little-endian
    always_ff @(posedge clk_sys) begin
        if (byte_valid) begin
            shift_q <= {byte_data, shift_q[23:8]};
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the CPR loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module cpr_loader_tb \
    -f vlog.f --Mdir obj_dir -o cpr_loader_sim

./obj_dir/cpr_loader_sim > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

/* vlog.f */
hw/cart_pkg.sv
hw/riff_pkg.sv
hw/riff_word_assembler.sv
hw/riff_parser.sv
hw/cart_block_writer.sv
hw/cpr_format_decoder.sv
hw/cpr_loader.sv
dv/cpr_loader_tb.sv
